// File: src/ps2_display_pkg.sv
package ps2_display_pkg;

  // -------------------------------------------------------------------------
  // Data types
  // -------------------------------------------------------------------------

  // One byte off the PS/2 data line
  typedef logic [7:0] byte_t;

  // Single decimal digit
  typedef logic [3:0] bcd_t;

  // Seven-segment pattern, active low
  // Bit 0 drives segment a, bit 6 drives segment g
  typedef logic [6:0] seg_t;

  // -------------------------------------------------------------------------
  // Display constants
  // -------------------------------------------------------------------------

  // Digits shown for one byte (0 to 255)
  parameter int NUM_DIGITS = 3;

  // Radix of the display
  parameter int DIGIT_BASE = 10;

  // Every segment dark
  parameter seg_t SEG_BLANK = 7'b111_1111;

endpackage

// File: src/ps2_line_sampler.sv
`timescale 1ns/1ps

module ps2_line_sampler
#(
  parameter int SAMPLE_COUNT = 16, // Samples per PS/2 bit
  parameter int SAMPLE_STEP  = 4   // System clocks between samples
)
(
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,    // Raw PS/2 clock line
  input  logic ps2_data,   // Raw PS/2 data line
  output logic bit_strobe, // One cycle per sampled bit
  output logic bit_value   // Majority result
);
  localparam int STEP_W = $clog2(SAMPLE_STEP + 1);
  localparam int CNT_W  = $clog2(SAMPLE_COUNT + 1);

  logic clk_meta;              // First sync stage
  logic clk_sync;
  logic clk_last;              // Previous synced level
  logic data_meta;
  logic data_sync;
  logic fall_edge;             // Registered falling edge of ps2_clk
  logic window_active;         // Sampling window running
  logic [STEP_W-1:0] step_cnt;
  logic [CNT_W-1:0]  sample_cnt;
  logic [CNT_W-1:0]  ones_cnt;  // Ones seen so far in window
  logic [CNT_W-1:0]  ones_next;
  logic sample_tick;
  logic last_sample;

  // -------------------------------------------------------------------------
  // Synchronizers and edge detect
  // -------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_meta  <= 1'b1; // Idle level of the line
      clk_sync  <= 1'b1;
      clk_last  <= 1'b1;
      fall_edge <= 1'b0;
    end
    else
    begin
      clk_meta  <= ps2_clk;
      clk_sync  <= clk_meta;
      clk_last  <= clk_sync;
      fall_edge <= clk_last & ~clk_sync; // High -> low seen
    end
  end

  // Data only needs two stages
  always_ff @(posedge clk)
  begin
    data_meta <= ps2_data;
    data_sync <= data_meta;
  end

  // -------------------------------------------------------------------------
  // Majority-vote window
  // -------------------------------------------------------------------------

  assign sample_tick = window_active && (step_cnt == STEP_W'(SAMPLE_STEP - 1));
  assign last_sample = sample_tick && (sample_cnt == CNT_W'(SAMPLE_COUNT - 1));
  assign ones_next   = ones_cnt + CNT_W'(data_sync);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      window_active <= 1'b0;
      step_cnt      <= '0;
      sample_cnt    <= '0;
      ones_cnt      <= '0;
      bit_strobe    <= 1'b0;
    end
    else
    begin
      bit_strobe <= 1'b0;
      if (fall_edge) // New edge restarts the window
      begin
        window_active <= 1'b1;
        step_cnt      <= '0;
        sample_cnt    <= '0;
        ones_cnt      <= '0;
      end
      else if (window_active)
      begin
        step_cnt <= sample_tick ? '0 : step_cnt + 1'b1;
        if (sample_tick)
        begin
          ones_cnt   <= ones_next;
          sample_cnt <= sample_cnt + 1'b1;
        end
        if (last_sample) // Window done, report bit
        begin
          window_active <= 1'b0;
          bit_strobe    <= 1'b1;
        end
      end
    end
  end

  // More than half of the samples high
  always_ff @(posedge clk)
  begin
    if (last_sample)
      bit_value <= (ones_next > CNT_W'(SAMPLE_COUNT / 2));
  end

endmodule

// File: src/ps2_frame_receiver.sv
`timescale 1ns/1ps

module ps2_frame_receiver
  import ps2_display_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  bit_strobe,  // From sampler
  input  logic  bit_value,
  output logic  byte_strobe, // Good frame
  output byte_t rx_byte,     // Valid with byte_strobe
  output logic  frame_error  // Bad parity or stop bit
);
  localparam int BIT_CNT_W = $clog2($bits(byte_t));

  typedef enum logic [1:0]
  {
    RX_IDLE,   // Wait for start bit
    RX_DATA,   // Eight data bits, LSB first
    RX_PARITY, // Odd parity bit
    RX_STOP    // Stop bit
  } rx_state_t;

  rx_state_t state;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic parity_acc; // XOR of data bits
  logic parity_ok;  // Data plus parity odd
  logic frame_good;

  // Stop bit must be 1 and parity must have checked out
  assign frame_good = parity_ok & bit_value;

  // -------------------------------------------------------------------------
  // Frame FSM
  // -------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= RX_IDLE;
      bit_cnt     <= '0;
      parity_acc  <= 1'b0;
      parity_ok   <= 1'b0;
      byte_strobe <= 1'b0;
      frame_error <= 1'b0;
    end
    else
    begin
      byte_strobe <= 1'b0; // Strobes last one cycle
      frame_error <= 1'b0;
      if (bit_strobe)
      begin
        case (state)
          RX_IDLE:
          begin
            if (!bit_value) // Start bit is low, else ignore
            begin
              state      <= RX_DATA;
              bit_cnt    <= '0;
              parity_acc <= 1'b0;
            end
          end
          RX_DATA:
          begin
            parity_acc <= parity_acc ^ bit_value;
            bit_cnt    <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_CNT_W'($bits(byte_t) - 1))
              state <= RX_PARITY;
          end
          RX_PARITY:
          begin
            // Odd count of ones overall
            parity_ok <= parity_acc ^ bit_value;
            state     <= RX_STOP;
          end
          RX_STOP:
          begin
            byte_strobe <= frame_good;
            frame_error <= ~frame_good;
            state       <= RX_IDLE;
          end
          default:
          begin
            state <= RX_IDLE;
          end
        endcase
      end
    end
  end

  // Data shift register, LSB arrives first
  always_ff @(posedge clk)
  begin
    if (bit_strobe && state == RX_DATA)
      rx_byte <= {bit_value, rx_byte[$bits(byte_t)-1:1]};
  end

endmodule

// File: src/seq_divider.sv
`timescale 1ns/1ps

module seq_divider
#(
  parameter int WIDTH   = 8,  // Dividend and quotient width
  parameter int DIVISOR = 10  // Constant divisor, nonzero
)
(
  input  logic             clk,
  input  logic             reset,
  input  logic             div_start, // Ignored while busy
  input  logic [WIDTH-1:0] dividend,
  output logic             div_done,  // WIDTH + 1 cycles after start
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder
);
  localparam int CNT_W = $clog2(WIDTH + 1);
  localparam logic [WIDTH+1:0] DIV_EXT = (WIDTH + 2)'(DIVISOR);

  logic busy;
  logic [CNT_W-1:0] step_cnt;  // Quotient bits left
  logic [WIDTH:0]   part_rem;  // Signed partial remainder
  logic [WIDTH-1:0] quo_shift; // Dividend bits out, quotient bits in
  logic [WIDTH+1:0] rem_shifted;
  logic [WIDTH+1:0] rem_step;
  logic [WIDTH+1:0] rem_fixed;
  logic last_step;

  // -------------------------------------------------------------------------
  // One non-restoring step
  // -------------------------------------------------------------------------

  // 2R plus next dividend bit, sign kept
  assign rem_shifted = {part_rem, quo_shift[WIDTH-1]};

  // Add when negative, subtract otherwise
  assign rem_step = part_rem[WIDTH] ? rem_shifted + DIV_EXT : rem_shifted - DIV_EXT;

  // Final correction back into 0 .. DIVISOR-1
  assign rem_fixed = rem_step[WIDTH+1] ? rem_step + DIV_EXT : rem_step;

  assign last_step = busy && (step_cnt == CNT_W'(1));

  assign quotient  = quo_shift;
  assign remainder = part_rem[WIDTH-1:0];

  // Control
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy     <= 1'b0;
      step_cnt <= '0;
      div_done <= 1'b0;
    end
    else
    begin
      div_done <= 1'b0;
      if (!busy)
      begin
        if (div_start)
        begin
          busy     <= 1'b1;
          step_cnt <= CNT_W'(WIDTH);
        end
      end
      else
      begin
        step_cnt <= step_cnt - 1'b1;
        if (last_step) // Remainder corrected this edge
        begin
          busy     <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk)
  begin
    if (!busy && div_start)
    begin
      part_rem  <= '0;
      quo_shift <= dividend;
    end
    else if (busy)
    begin
      quo_shift <= {quo_shift[WIDTH-2:0], ~rem_step[WIDTH+1]}; // 1 when R >= 0
      part_rem  <= last_step ? rem_fixed[WIDTH:0] : rem_step[WIDTH:0];
    end
  end

endmodule

// File: src/decimal_converter.sv
`timescale 1ns/1ps

module decimal_converter
  import ps2_display_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  byte_strobe,   // Dropped unless idle
  input  byte_t rx_byte,
  output logic  digits_strobe, // All digits valid
  output bcd_t  digit_ones,
  output bcd_t  digit_tens,
  output bcd_t  digit_hundreds
);
  localparam int DIV_WIDTH = $bits(byte_t);
  localparam int ROUND_W   = $clog2(NUM_DIGITS);

  typedef enum logic [1:0]
  {
    CONV_IDLE,
    CONV_DIVIDE, // One division per digit
    CONV_FINISH  // Strobe cycle
  } conv_state_t;

  conv_state_t state;
  logic [ROUND_W-1:0] round;  // Digit being produced, ones first
  logic launch;               // Start next round
  logic last_round;
  logic div_start;
  logic div_done;
  byte_t dividend;
  byte_t next_dividend;       // Quotient of previous round
  byte_t quotient;
  byte_t remainder;
  bcd_t digits_q [NUM_DIGITS];

  assign last_round = (round == ROUND_W'(NUM_DIGITS - 1));

  // First round starts right on the byte strobe
  assign div_start = ((state == CONV_IDLE) && byte_strobe) || launch;
  assign dividend  = (state == CONV_IDLE) ? rx_byte : next_dividend;

  assign digits_strobe  = (state == CONV_FINISH);
  assign digit_ones     = digits_q[0];
  assign digit_tens     = digits_q[1];
  assign digit_hundreds = digits_q[2];

  seq_divider
  #(
    .WIDTH   (DIV_WIDTH),
    .DIVISOR (DIGIT_BASE)
  )
  seq_divider_i
  (
    .clk       (clk),
    .reset     (reset),
    .div_start (div_start),
    .dividend  (dividend),
    .div_done  (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  // -------------------------------------------------------------------------
  // Conversion FSM
  // -------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state  <= CONV_IDLE;
      round  <= '0;
      launch <= 1'b0;
    end
    else
    begin
      launch <= 1'b0;
      case (state)
        CONV_IDLE:
        begin
          if (byte_strobe)
          begin
            state <= CONV_DIVIDE;
            round <= '0;
          end
        end
        CONV_DIVIDE:
        begin
          if (div_done)
          begin
            if (last_round)
              state <= CONV_FINISH;
            else
            begin
              round  <= round + 1'b1;
              launch <= 1'b1; // Quotient feeds back
            end
          end
        end
        CONV_FINISH:
        begin
          state <= CONV_IDLE;
        end
        default:
        begin
          state <= CONV_IDLE;
        end
      endcase
    end
  end

  // Remainder is the next digit, quotient the next dividend
  always_ff @(posedge clk)
  begin
    if (state == CONV_DIVIDE && div_done)
    begin
      digits_q[round] <= remainder[$bits(bcd_t)-1:0];
      next_dividend   <= quotient;
    end
  end

endmodule

// File: src/segment_display.sv
`timescale 1ns/1ps

module segment_display
  import ps2_display_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic digits_strobe,
  input  bcd_t digit_ones,
  input  bcd_t digit_tens,
  input  bcd_t digit_hundreds,
  output seg_t seg_ones,     // Active low
  output seg_t seg_tens,
  output seg_t seg_hundreds,
  output logic seg_update    // Patterns just changed
);
  // Hex table, active high, bits g down to a
  //     a
  //   f   b
  //     g
  //   e   c
  //     d
  localparam seg_t HEX_LUT [16] = '{
    7'b0111111, // 0
    7'b0000110, // 1
    7'b1011011, // 2
    7'b1001111, // 3
    7'b1100110, // 4
    7'b1101101, // 5
    7'b1111101, // 6
    7'b0000111, // 7
    7'b1111111, // 8
    7'b1101111, // 9
    7'b1110111, // A
    7'b1111100, // b
    7'b0111001, // C
    7'b1011110, // d
    7'b1111001, // E
    7'b1110001  // F
  };

  // Board segments light on a low level
  function automatic seg_t encode(input bcd_t digit);
    return ~HEX_LUT[digit];
  endfunction

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      seg_ones     <= SEG_BLANK;
      seg_tens     <= SEG_BLANK;
      seg_hundreds <= SEG_BLANK;
      seg_update   <= 1'b0;
    end
    else
    begin
      seg_update <= digits_strobe;
      if (digits_strobe)
      begin
        seg_ones     <= encode(digit_ones);
        seg_tens     <= encode(digit_tens);
        seg_hundreds <= encode(digit_hundreds);
      end
    end
  end

endmodule

// File: src/ps2_display_top.sv
`timescale 1ns/1ps

module ps2_display_top
  import ps2_display_pkg::*;
#(
  parameter int SAMPLE_COUNT = 16, // Votes per PS/2 bit
  parameter int SAMPLE_STEP  = 4   // Clocks between votes
)
(
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,
  input  logic ps2_data,
  output seg_t seg_ones,
  output seg_t seg_tens,
  output seg_t seg_hundreds,
  output logic seg_update,
  output logic frame_error
);
  logic  bit_strobe;
  logic  bit_value;
  logic  byte_strobe;
  byte_t rx_byte;
  logic  digits_strobe;
  bcd_t  digit_ones;
  bcd_t  digit_tens;
  bcd_t  digit_hundreds;

  // -------------------------------------------------------------------------
  // PS/2 input side
  // -------------------------------------------------------------------------

  ps2_line_sampler
  #(
    .SAMPLE_COUNT (SAMPLE_COUNT),
    .SAMPLE_STEP  (SAMPLE_STEP)
  )
  ps2_line_sampler_i
  (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .bit_strobe (bit_strobe),
    .bit_value  (bit_value)
  );

  ps2_frame_receiver ps2_frame_receiver_i
  (
    .clk         (clk),
    .reset       (reset),
    .bit_strobe  (bit_strobe),
    .bit_value   (bit_value),
    .byte_strobe (byte_strobe),
    .rx_byte     (rx_byte),
    .frame_error (frame_error)
  );

  // -------------------------------------------------------------------------
  // Decimal conversion and display
  // -------------------------------------------------------------------------

  decimal_converter decimal_converter_i
  (
    .clk            (clk),
    .reset          (reset),
    .byte_strobe    (byte_strobe),
    .rx_byte        (rx_byte),
    .digits_strobe  (digits_strobe),
    .digit_ones     (digit_ones),
    .digit_tens     (digit_tens),
    .digit_hundreds (digit_hundreds)
  );

  segment_display segment_display_i
  (
    .clk            (clk),
    .reset          (reset),
    .digits_strobe  (digits_strobe),
    .digit_ones     (digit_ones),
    .digit_tens     (digit_tens),
    .digit_hundreds (digit_hundreds),
    .seg_ones       (seg_ones),
    .seg_tens       (seg_tens),
    .seg_hundreds   (seg_hundreds),
    .seg_update     (seg_update)
  );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
  parameter int PERIOD_NS    = 10, // System clock period
  parameter int RESET_CYCLES = 5   // Rising edges with reset held
)
(
  output logic clk,
  output logic reset
);
  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset released 1 ns after an edge
  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// File: verif/ps2_display_tb.sv
`timescale 1ns/1ps

module ps2_display_tb
  import ps2_display_pkg::*;
();
  localparam int HALF_PERIOD    = 200;             // PS/2 clock half period, system clocks
  localparam int SETUP_CYCLES   = HALF_PERIOD / 2; // Data change to edge
  localparam int RESULT_WINDOW  = 150;             // Stop edge to seg_update, at most
  localparam int GLITCH_DELAY   = 8;               // Edge to glitch, lands on one vote
  localparam int GLITCH_CYCLES  = 3;
  localparam int FRAME_GAP      = 100;             // Idle between frames
  localparam int NUM_RANDOM     = 40;
  localparam int NUM_GLITCHED   = 6;
  localparam int FRAME_CYCLES   = 22 * HALF_PERIOD; // 11 bits, two halves each
  localparam int MAX_FRAMES     = 60;
  localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES + 36000;

  localparam byte_t BOUNDARY [6] = '{8'd0, 8'd9, 8'd10, 8'd99, 8'd100, 8'd255};

  logic clk;
  logic reset;
  logic ps2_clk;
  logic ps2_data;
  seg_t seg_ones;
  seg_t seg_tens;
  seg_t seg_hundreds;
  logic seg_update;
  logic frame_error;
  int   update_count = 0; // seg_update pulses so far
  int   error_count  = 0; // frame_error pulses so far
  int   cycle_count  = 0;
  int unsigned seed_value;

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) tb_clock_gen_i
  (
    .clk   (clk),
    .reset (reset)
  );

  ps2_display_top #(.SAMPLE_COUNT(16), .SAMPLE_STEP(4)) ps2_display_top_i
  (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .seg_ones     (seg_ones),
    .seg_tens     (seg_tens),
    .seg_hundreds (seg_hundreds),
    .seg_update   (seg_update),
    .frame_error  (frame_error)
  );

  // --------------------------------------------------------------------------
  // Reporting, monitors and watchdog
  // --------------------------------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic value_mismatch(input string what);
    abort_run($sformatf("[FAIL] t=%0t ns: %s", $time, what));
  endtask

  // Strobes counted on the falling clock edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (seg_update)
        update_count = update_count + 1;
      if (frame_error)
        error_count = error_count + 1;
    end
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      abort_run("Timeout: the run went past its cycle limit without finishing");
  end

  // --------------------------------------------------------------------------
  // Model and frame driver
  // --------------------------------------------------------------------------

  // Inputs move 1 ns after the edge
  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // Active-low digit patterns with bit 6 as segment g
  function automatic seg_t expected_pattern(input int digit);
    case (digit)
      0: return 7'b1000000;
      1: return 7'b1111001;
      2: return 7'b0100100;
      3: return 7'b0110000;
      4: return 7'b0011001;
      5: return 7'b0010010;
      6: return 7'b0000010;
      7: return 7'b1111000;
      8: return 7'b0000000;
      9: return 7'b0010000;
      default: return SEG_BLANK;
    endcase
  endfunction

  task automatic check_display(input byte_t value);
    seg_t exp_hundreds;
    seg_t exp_tens;
    seg_t exp_ones;
    exp_hundreds = expected_pattern(int'(value) / 100);
    exp_tens     = expected_pattern((int'(value) / 10) % 10);
    exp_ones     = expected_pattern(int'(value) % 10);
    assert (seg_hundreds == exp_hundreds && seg_tens == exp_tens && seg_ones == exp_ones)
    else value_mismatch($sformatf("byte %0d shows %b %b %b, expected %b %b %b", value,
      seg_hundreds, seg_tens, seg_ones, exp_hundreds, exp_tens, exp_ones));
  endtask

  // Sends one 11-bit frame and checks the outcome
  task automatic send_frame(input byte_t value, input logic flip_parity,
                            input logic stop_bit, input logic glitch);
    logic [10:0] frame;
    logic expect_good;
    logic result_seen;
    int   upd_before;
    int   err_before;
    int   waited;
    seg_t old_hundreds;
    seg_t old_tens;
    seg_t old_ones;
    frame        = {stop_bit, (~^value) ^ flip_parity, value, 1'b0}; // Odd parity
    expect_good  = !flip_parity && stop_bit;
    result_seen  = 1'b0;
    wait_cycles(FRAME_GAP);
    upd_before   = update_count;
    err_before   = error_count;
    old_hundreds = seg_hundreds;
    old_tens     = seg_tens;
    old_ones     = seg_ones;
    for (int i = 0; i < 11; i++)
    begin
      ps2_data = frame[i]; // Changes mid-way through the high phase
      wait_cycles(SETUP_CYCLES);
      ps2_clk = 1'b0;
      waited  = 0;
      if (glitch)
      begin
        wait_cycles(GLITCH_DELAY);
        ps2_data = ~frame[i]; // Short inverted spike inside the vote window
        wait_cycles(GLITCH_CYCLES);
        ps2_data = frame[i];
        waited   = GLITCH_DELAY + GLITCH_CYCLES;
      end
      if (i == 10) // Stop edge starts the result watch
      begin
        while (update_count == upd_before && error_count == err_before &&
               waited < RESULT_WINDOW)
        begin
          wait_cycles(1);
          waited++;
        end
        result_seen = (update_count != upd_before) || (error_count != err_before);
      end
      wait_cycles(HALF_PERIOD - waited);
      ps2_clk = 1'b1;
      wait_cycles(SETUP_CYCLES);
    end

    assert (result_seen)
    else abort_run($sformatf("No seg_update or frame_error within %0d cycles of the stop edge",
      RESULT_WINDOW));
    if (expect_good)
    begin
      assert (update_count == upd_before + 1 && error_count == err_before)
      else value_mismatch($sformatf("byte %0d gave %0d updates and %0d errors, expected 1 and 0",
        value, update_count - upd_before, error_count - err_before));
      check_display(value);
    end
    else
    begin
      assert (error_count == err_before + 1 && update_count == upd_before)
      else value_mismatch($sformatf("bad frame %0d gave %0d updates and %0d errors", value,
        update_count - upd_before, error_count - err_before));
      assert (seg_hundreds == old_hundreds && seg_tens == old_tens && seg_ones == old_ones)
      else value_mismatch($sformatf("bad frame %0d changed the display", value));
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial
  begin
    ps2_clk    = 1'b1; // Both lines idle high
    ps2_data   = 1'b1;
    seed_value = $urandom(20362);
    wait (reset == 1'b0);
    wait_cycles(20);

    assert (seg_ones == SEG_BLANK && seg_tens == SEG_BLANK && seg_hundreds == SEG_BLANK)
    else value_mismatch("segments not blank after reset");
    assert (update_count == 0 && error_count == 0 && !seg_update && !frame_error)
    else value_mismatch("strobe seen before the first frame");

    for (int i = 0; i < NUM_RANDOM; i++)
      send_frame(byte_t'($urandom_range(0, 255)), 1'b0, 1'b1, 1'b0);

    for (int i = 0; i < $size(BOUNDARY); i++)
      send_frame(BOUNDARY[i], 1'b0, 1'b1, 1'b0);

    send_frame(8'hA5, 1'b1, 1'b1, 1'b0); // Parity flipped
    send_frame(8'h3C, 1'b0, 1'b0, 1'b0); // Stop bit low
    send_frame(8'h7E, 1'b0, 1'b1, 1'b0); // Recovery

    for (int i = 0; i < NUM_GLITCHED; i++)
      send_frame(byte_t'($urandom_range(0, 255)), 1'b0, 1'b1, 1'b1);

    $display("Test passed");
    $finish;
  end

endmodule

// File: ps2_display.f
src/ps2_display_pkg.sv
src/ps2_line_sampler.sv
src/ps2_frame_receiver.sv
src/seq_divider.sv
src/decimal_converter.sv
src/segment_display.sv
src/ps2_display_top.sv
verif/tb_clock_gen.sv
verif/ps2_display_tb.sv

// File: Bender.yml
package:
  name: ps2_display

sources:
  - src/ps2_display_pkg.sv
  - src/ps2_line_sampler.sv
  - src/ps2_frame_receiver.sv
  - src/seq_divider.sv
  - src/decimal_converter.sv
  - src/segment_display.sv
  - src/ps2_display_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/ps2_display_tb.sv
